//--- build.f
src/bpm_pkg.sv
src/bpm_reg_bank.sv
src/bpm_read_mux.sv
src/afe_ctrl.sv
src/bpm_ctrl_top.sv
verification/tb_bpm_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_bpm_ctrl \
	-f build.f \
	-o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Verification passed" sim.log; then
	echo "Simulation PASS"
	exit 0
else
	echo "Simulation FAIL"
	exit 1
fi

//--- src/afe_ctrl.sv
`timescale 1ns/10ps

module afe_ctrl
	import bpm_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [DATA_W-1:0] control_reg,
	input  logic [DATA_W-1:0] afe_ctrl_reg,
	input  logic [VGA_W-1:0]  auto_att,
	input  logic              cal_on,
	input  logic              trig_in,
	output logic              afe_pickup,
	output logic              afe_cal,
	output logic [VGA_W-1:0]  vga_gain,
	output logic              sma_out,
	output logic              att_le,
	output logic              att_clk,
	output logic              att_data
);

	localparam int CNT_W = $clog2(ATT_W);

	logic             auto_mode;
	logic [ATT_W-1:0] att_setting;

	att_state_e       state, state_nxt;
	logic [CNT_W-1:0] bit_cnt, bit_cnt_nxt;
	logic [ATT_W-1:0] shift_q, shift_nxt;    // Rotates once per bit
	logic [ATT_W-1:0] loaded_q, loaded_nxt;  // Last value latched into the part

	////////////////////////////////////////////////////////////////////////////
	// Front-end selects
	////////////////////////////////////////////////////////////////////////////
	assign afe_pickup = control_reg[13] ? 1'b1 : cal_on;  // Forced pickup or cal sequencer
	assign afe_cal    = ~afe_pickup;

	assign auto_mode = control_reg[6];  // Auto ranging
	assign vga_gain  = auto_mode ? auto_att : afe_ctrl_reg[VGA_W-1:0];

	// External NAND on the SMA path idles high
	assign sma_out = control_reg[3] ? ~trig_in : 1'b1;

	////////////////////////////////////////////////////////////////////////////
	// Attenuator serial loader
	////////////////////////////////////////////////////////////////////////////
	assign att_setting = afe_ctrl_reg[13:8];

	always_comb begin
		state_nxt   = state;
		bit_cnt_nxt = bit_cnt;
		shift_nxt   = shift_q;
		loaded_nxt  = loaded_q;
		case (state)
			ATT_IDLE: begin
				if (att_setting != loaded_q) begin
					shift_nxt   = att_setting;
					bit_cnt_nxt = '0;
					state_nxt   = ATT_SETUP;
				end
			end
			ATT_SETUP:
				state_nxt = ATT_CLOCK;
			ATT_CLOCK: begin
				// After six rotations the frame value is back in place
				shift_nxt = {shift_q[ATT_W-2:0], shift_q[ATT_W-1]};
				if (bit_cnt == CNT_W'(ATT_W - 1)) begin
					state_nxt = ATT_LATCH;
				end else begin
					bit_cnt_nxt = bit_cnt + 1'b1;
					state_nxt   = ATT_SETUP;
				end
			end
			ATT_LATCH: begin
				loaded_nxt = shift_q;
				state_nxt  = ATT_IDLE;  // Rechecks for a change made mid frame
			end
			default:
				state_nxt = ATT_IDLE;
		endcase
	end

	// Outputs registered from the next state so the pins never glitch
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ATT_IDLE;
			bit_cnt  <= '0;
			shift_q  <= '0;
			loaded_q <= '0;
			att_clk  <= 1'b0;
			att_le   <= 1'b0;
			att_data <= 1'b0;
		end else begin
			state    <= state_nxt;
			bit_cnt  <= bit_cnt_nxt;
			shift_q  <= shift_nxt;
			loaded_q <= loaded_nxt;
			att_clk  <= (state_nxt == ATT_CLOCK);
			att_le   <= (state_nxt == ATT_LATCH);
			att_data <= (state_nxt == ATT_SETUP || state_nxt == ATT_CLOCK) &&
				shift_nxt[ATT_W-1];  // MSB first
		end
	end

	// Value recorded at the latch is the one the frame started with
	a_frame_restored: assert property (@(posedge clk) disable iff (!rst_n)
		att_le |-> shift_q == $past(shift_q, 2 * ATT_W));

	// Data bit held while the part clocks it in
	a_data_held: assert property (@(posedge clk) disable iff (!rst_n)
		att_clk |-> $stable(att_data));

endmodule

//--- src/bpm_ctrl_top.sv
`timescale 1ns/10ps

module bpm_ctrl_top
	import bpm_pkg::*;
#(
	parameter logic [BUS_W-1:0] BASE_ADDR = 32'h4171_0000
) (
	input  logic                          clk,
	input  logic                          rst_n,
	// Processor bus
	input  logic                          bus_en,
	input  logic [WE_W-1:0]               bus_we,
	input  logic [BUS_W-1:0]              bus_addr,
	input  logic [BUS_W-1:0]              bus_wr_data,
	output logic [BUS_W-1:0]              bus_rd_data,
	// Results from the processing chain
	input  logic [DATA_W-1:0]             pos_x,
	input  logic [DATA_W-1:0]             pos_y,
	input  logic [DATA_W-1:0]             pos_s,
	input  logic [N_CHAN-1:0][GAIN_W-1:0] chan_power,
	input  logic [VGA_W-1:0]              auto_att,
	input  logic                          cal_on,
	input  logic                          trig_in,
	// Configuration to the processing chain
	output logic [DATA_W-1:0]             control_reg,
	output logic [DATA_W-1:0]             bpm_dia,
	output logic [DATA_W-1:0]             trig_th,
	output logic [DATA_W-1:0]             trig_dt,
	output logic [DATA_W-1:0]             trig_dl,
	output logic [DATA_W-1:0]             evt_len,
	output logic [DATA_W-1:0]             evt_tail_len,
	output logic [DATA_W-1:0]             bl_len,
	output logic [N_CHAN-1:0][GAIN_W-1:0] chan_gain,
	// Front end
	output logic                          afe_pickup,
	output logic                          afe_cal,
	output logic [VGA_W-1:0]              vga_gain,
	output logic                          sma_out,
	output logic                          att_le,
	output logic                          att_clk,
	output logic                          att_data
);

	logic [DATA_W-1:0] afe_ctrl_reg;

	bpm_reg_bank #(.BASE_ADDR(BASE_ADDR)) i_reg_bank (
		.clk, .rst_n, .bus_en, .bus_we, .bus_addr, .bus_wr_data,
		.control_reg, .afe_ctrl_reg, .bpm_dia, .trig_th, .trig_dt, .trig_dl,
		.evt_len, .evt_tail_len, .bl_len, .chan_gain
	);

	bpm_read_mux #(.BASE_ADDR(BASE_ADDR)) i_read_mux (
		.clk, .rst_n, .bus_en, .bus_we, .bus_addr,
		.control_reg, .afe_ctrl_reg, .bpm_dia, .trig_th, .trig_dt, .trig_dl,
		.evt_len, .evt_tail_len, .bl_len, .chan_gain,
		.pos_x, .pos_y, .pos_s, .chan_power,
		.vga_gain,  // Gain actually driven to the VGA
		.bus_rd_data
	);

	afe_ctrl i_afe_ctrl (
		.clk, .rst_n, .control_reg, .afe_ctrl_reg, .auto_att, .cal_on, .trig_in,
		.afe_pickup, .afe_cal, .vga_gain, .sma_out,
		.att_le, .att_clk, .att_data
	);

endmodule

//--- src/bpm_pkg.sv
package bpm_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////
	localparam int DATA_W = 16;  // Config and position registers
	localparam int BUS_W  = 32;  // Bus address and data
	localparam int WE_W   = BUS_W / 8;
	localparam int GAIN_W = 32;  // Channel gain and power
	localparam int VGA_W  = 5;
	localparam int ATT_W  = 6;   // Digital attenuator setting
	localparam int N_CHAN = 4;   // Pickups A to D
	localparam int OFS_W  = 8;   // Register word offset width

	localparam logic [BUS_W-1:0] FPGA_VERSION = 32'h0002_0105;

	// Word offsets, byte address is base plus four times the offset
	typedef enum logic [OFS_W-1:0] {
		CR              = 8'h01,
		FPGA_VER        = 8'h02,
		CHA_POWER       = 8'h04,
		CHB_POWER       = 8'h05,
		CHC_POWER       = 8'h06,
		CHD_POWER       = 8'h07,
		X               = 8'h08,
		Y               = 8'h09,
		S               = 8'h0A,
		TRIG_DL         = 8'h16,
		BPM_DIA         = 8'h17,
		TRIG_TH         = 8'h18,
		TRIG_DT         = 8'h19,
		EVT_LEN         = 8'h1A,
		EVT_TAIL_LEN    = 8'h1B,
		BL_LEN          = 8'h1C,
		AFE_CTRL        = 8'h58,
		CHA_GAIN        = 8'h60,
		CHB_GAIN        = 8'h61,
		CHC_GAIN        = 8'h62,
		CHD_GAIN        = 8'h63,
		ACTUAL_VGA_GAIN = 8'h6D
	} reg_addr_e;

	// Attenuator serial loader
	typedef enum logic [1:0] {
		ATT_IDLE,
		ATT_SETUP,   // Data out, clock low
		ATT_CLOCK,   // Clock high
		ATT_LATCH    // Latch enable pulse
	} att_state_e;

	// Word aligned and inside the register window
	function automatic logic in_window(input logic [BUS_W-1:0] addr,
		input logic [BUS_W-1:0] base);
		logic [BUS_W-1:0] rel;
		rel = addr - base;
		return (rel[1:0] == 2'b00) && (rel[BUS_W-1:OFS_W+2] == '0);
	endfunction

	function automatic reg_addr_e word_ofs(input logic [BUS_W-1:0] addr,
		input logic [BUS_W-1:0] base);
		logic [BUS_W-1:0] rel;
		rel = addr - base;
		return reg_addr_e'(rel[OFS_W+1:2]);
	endfunction

endpackage

//--- src/bpm_read_mux.sv
`timescale 1ns/10ps

module bpm_read_mux
	import bpm_pkg::*;
#(
	parameter logic [BUS_W-1:0] BASE_ADDR = 32'h4171_0000
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          bus_en,
	input  logic [WE_W-1:0]               bus_we,
	input  logic [BUS_W-1:0]              bus_addr,
	input  logic [DATA_W-1:0]             control_reg,
	input  logic [DATA_W-1:0]             afe_ctrl_reg,
	input  logic [DATA_W-1:0]             bpm_dia,
	input  logic [DATA_W-1:0]             trig_th,
	input  logic [DATA_W-1:0]             trig_dt,
	input  logic [DATA_W-1:0]             trig_dl,
	input  logic [DATA_W-1:0]             evt_len,
	input  logic [DATA_W-1:0]             evt_tail_len,
	input  logic [DATA_W-1:0]             bl_len,
	input  logic [N_CHAN-1:0][GAIN_W-1:0] chan_gain,
	input  logic [DATA_W-1:0]             pos_x,
	input  logic [DATA_W-1:0]             pos_y,
	input  logic [DATA_W-1:0]             pos_s,
	input  logic [N_CHAN-1:0][GAIN_W-1:0] chan_power,
	input  logic [VGA_W-1:0]              vga_gain,
	output logic [BUS_W-1:0]              bus_rd_data
);

	localparam int EXT_W = BUS_W - DATA_W;

	logic             rd_en;
	logic             rd_hit;  // Offset is a mapped register
	logic [BUS_W-1:0] rd_word;

	assign rd_en = bus_en && (bus_we == '0) && in_window(bus_addr, BASE_ADDR);

	// Read word select and extension
	always_comb begin
		rd_hit  = 1'b1;
		rd_word = '0;
		case (word_ofs(bus_addr, BASE_ADDR))
			CR:              rd_word = {{EXT_W{control_reg[DATA_W-1]}}, control_reg};
			AFE_CTRL:        rd_word = {{EXT_W{afe_ctrl_reg[DATA_W-1]}}, afe_ctrl_reg};
			FPGA_VER:        rd_word = FPGA_VERSION;
			BPM_DIA:         rd_word = BUS_W'(bpm_dia);
			TRIG_TH:         rd_word = BUS_W'(trig_th);
			TRIG_DT:         rd_word = BUS_W'(trig_dt);
			TRIG_DL:         rd_word = BUS_W'(trig_dl);
			EVT_LEN:         rd_word = BUS_W'(evt_len);
			EVT_TAIL_LEN:    rd_word = BUS_W'(evt_tail_len);
			BL_LEN:          rd_word = BUS_W'(bl_len);
			X:               rd_word = BUS_W'(pos_x);
			Y:               rd_word = BUS_W'(pos_y);
			S:               rd_word = BUS_W'(pos_s);
			CHA_POWER:       rd_word = chan_power[0];
			CHB_POWER:       rd_word = chan_power[1];
			CHC_POWER:       rd_word = chan_power[2];
			CHD_POWER:       rd_word = chan_power[3];
			CHA_GAIN:        rd_word = chan_gain[0];
			CHB_GAIN:        rd_word = chan_gain[1];
			CHC_GAIN:        rd_word = chan_gain[2];
			CHD_GAIN:        rd_word = chan_gain[3];
			ACTUAL_VGA_GAIN: rd_word = BUS_W'(vga_gain);  // Gain in use, manual or auto
			default:         rd_hit  = 1'b0;
		endcase
	end

	// Holds the last mapped read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			bus_rd_data <= '0;
		else if (rd_en && rd_hit)
			bus_rd_data <= rd_word;
	end

endmodule

//--- src/bpm_reg_bank.sv
`timescale 1ns/10ps

module bpm_reg_bank
	import bpm_pkg::*;
#(
	parameter logic [BUS_W-1:0] BASE_ADDR = 32'h4171_0000
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          bus_en,
	input  logic [WE_W-1:0]               bus_we,
	input  logic [BUS_W-1:0]              bus_addr,
	input  logic [BUS_W-1:0]              bus_wr_data,
	output logic [DATA_W-1:0]             control_reg,
	output logic [DATA_W-1:0]             afe_ctrl_reg,
	output logic [DATA_W-1:0]             bpm_dia,
	output logic [DATA_W-1:0]             trig_th,
	output logic [DATA_W-1:0]             trig_dt,
	output logic [DATA_W-1:0]             trig_dl,
	output logic [DATA_W-1:0]             evt_len,
	output logic [DATA_W-1:0]             evt_tail_len,
	output logic [DATA_W-1:0]             bl_len,
	output logic [N_CHAN-1:0][GAIN_W-1:0] chan_gain
);

	logic        wr_en;
	reg_addr_e   wr_ofs;
	logic [DATA_W-1:0] wr_lo;

	// Only a full mask counts as a write
	assign wr_en  = bus_en && (bus_we == '1) && in_window(bus_addr, BASE_ADDR);
	assign wr_ofs = word_ofs(bus_addr, BASE_ADDR);
	assign wr_lo  = bus_wr_data[DATA_W-1:0];  // 16-bit registers keep the low half

	////////////////////////////////////////////////////////////////////////////
	// Configuration registers
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			control_reg  <= '0;
			afe_ctrl_reg <= '0;
			bpm_dia      <= '0;
			trig_th      <= '0;
			trig_dt      <= '0;
			trig_dl      <= '0;
			evt_len      <= '0;
			evt_tail_len <= '0;
			bl_len       <= '0;
			chan_gain    <= '0;
		end else if (wr_en) begin
			case (wr_ofs)
				CR:           control_reg  <= wr_lo;
				AFE_CTRL:     afe_ctrl_reg <= wr_lo;  // VGA gain and attenuator
				BPM_DIA:      bpm_dia      <= wr_lo;
				TRIG_TH:      trig_th      <= wr_lo;
				TRIG_DT:      trig_dt      <= wr_lo;
				TRIG_DL:      trig_dl      <= wr_lo;
				EVT_LEN:      evt_len      <= wr_lo;
				EVT_TAIL_LEN: evt_tail_len <= wr_lo;
				BL_LEN:       bl_len       <= wr_lo;
				// Gains take the full word
				CHA_GAIN:     chan_gain[0] <= bus_wr_data[GAIN_W-1:0];
				CHB_GAIN:     chan_gain[1] <= bus_wr_data[GAIN_W-1:0];
				CHC_GAIN:     chan_gain[2] <= bus_wr_data[GAIN_W-1:0];
				CHD_GAIN:     chan_gain[3] <= bus_wr_data[GAIN_W-1:0];
				default: ;  // Read-only or unmapped
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus protocol check
	////////////////////////////////////////////////////////////////////////////
	// Mixed byte masks are not part of the protocol, the transfer is dropped
	a_we_mask: assert property (@(posedge clk) disable iff (!rst_n)
		bus_en |-> (bus_we == '1 || bus_we == '0))
	else
		$warning("Partial write mask %h ignored", bus_we);

endmodule

//--- verification/tb_bpm_ctrl.sv
`timescale 1ns/10ps

module tb_bpm_ctrl
	import bpm_pkg::*;
();

	localparam logic [BUS_W-1:0] BASE_ADDR = 32'h4171_0000;
	localparam int CLK_PERIOD = 20;
	localparam int N_OPS      = 2000;  // Watchdog budget
	localparam int OP_CYCLES  = 20;
	localparam int N_CFG      = 13;

	logic                          clk;
	logic                          rst_n;
	logic                          bus_en;
	logic [WE_W-1:0]               bus_we;
	logic [BUS_W-1:0]              bus_addr;
	logic [BUS_W-1:0]              bus_wr_data;
	logic [BUS_W-1:0]              bus_rd_data;
	logic [DATA_W-1:0]             pos_x, pos_y, pos_s;
	logic [N_CHAN-1:0][GAIN_W-1:0] chan_power;
	logic [VGA_W-1:0]              auto_att;
	logic                          cal_on;
	logic                          trig_in;
	logic [DATA_W-1:0]             control_reg, bpm_dia, trig_th, trig_dt, trig_dl;
	logic [DATA_W-1:0]             evt_len, evt_tail_len, bl_len;
	logic [N_CHAN-1:0][GAIN_W-1:0] chan_gain;
	logic                          afe_pickup, afe_cal, sma_out;
	logic [VGA_W-1:0]              vga_gain;
	logic                          att_le, att_clk, att_data;

	// Reference model state
	integer           seed;
	logic [31:0]      shadow [0:255];  // Indexed by word offset
	logic [31:0]      rd_expect;
	logic [ATT_W-1:0] att_loaded;      // Last setting latched into the attenuator
	logic [ATT_W-1:0] att_bits;
	int               att_nbits;
	int               frames;
	int               frames_expected;
	logic             att_clk_prev;

	reg_addr_e cfg_ofs [N_CFG] = '{CR, AFE_CTRL, BPM_DIA, TRIG_TH, TRIG_DT, TRIG_DL, EVT_LEN,
		EVT_TAIL_LEN, BL_LEN, CHA_GAIN, CHB_GAIN, CHC_GAIN, CHD_GAIN};
	reg_addr_e meas_ofs [7] = '{X, Y, S, CHA_POWER, CHB_POWER, CHC_POWER, CHD_POWER};

	bpm_ctrl_top #(.BASE_ADDR(BASE_ADDR)) i_dut (.*);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#((N_OPS * OP_CYCLES + 200) * CLK_PERIOD);
		$display("Timeout: the run did not finish in the time allowed for its operations");
		$display("Verification failed");
		$fatal(1, "Watchdog expired");
	end

	////////////////////////////////////////////////////////////////////////////
	// Model helpers
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic logic [31:0] reg_addr(input logic [7:0] ofs);
		return BASE_ADDR + {22'h0, ofs, 2'b00};
	endfunction

	function automatic logic [7:0] pick_cfg();
		logic [31:0] r;
		r = rand32();
		return cfg_ofs[r % N_CFG];
	endfunction

	function automatic logic mapped(input logic [7:0] ofs);
		case (ofs)
			CR, FPGA_VER, CHA_POWER, CHB_POWER, CHC_POWER, CHD_POWER, X, Y, S,
			TRIG_DL, BPM_DIA, TRIG_TH, TRIG_DT, EVT_LEN, EVT_TAIL_LEN, BL_LEN, AFE_CTRL,
			CHA_GAIN, CHB_GAIN, CHC_GAIN, CHD_GAIN, ACTUAL_VGA_GAIN: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [VGA_W-1:0] vga_model();
		return shadow[CR][6] ? auto_att : shadow[AFE_CTRL][4:0];  // Auto ranging bit
	endfunction

	function automatic logic [31:0] expect_read(input logic [7:0] ofs);
		case (ofs)
			CR, AFE_CTRL:    return {{16{shadow[ofs][15]}}, shadow[ofs][15:0]};
			FPGA_VER:        return FPGA_VERSION;
			X:               return {16'h0, pos_x};
			Y:               return {16'h0, pos_y};
			S:               return {16'h0, pos_s};
			CHA_POWER:       return chan_power[0];
			CHB_POWER:       return chan_power[1];
			CHC_POWER:       return chan_power[2];
			CHD_POWER:       return chan_power[3];
			ACTUAL_VGA_GAIN: return {27'h0, vga_model()};
			default:         return shadow[ofs];  // Stored already extended
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			$display("Verification failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "Run aborted");
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_outputs(input string name);
		check({name, " control_reg"}, shadow[CR], 32'(control_reg));
		check({name, " bpm_dia"}, shadow[BPM_DIA], 32'(bpm_dia));
		check({name, " trig_th"}, shadow[TRIG_TH], 32'(trig_th));
		check({name, " trig_dt"}, shadow[TRIG_DT], 32'(trig_dt));
		check({name, " trig_dl"}, shadow[TRIG_DL], 32'(trig_dl));
		check({name, " evt_len"}, shadow[EVT_LEN], 32'(evt_len));
		check({name, " evt_tail_len"}, shadow[EVT_TAIL_LEN], 32'(evt_tail_len));
		check({name, " bl_len"}, shadow[BL_LEN], 32'(bl_len));
		check({name, " chan_gain a"}, shadow[CHA_GAIN], chan_gain[0]);
		check({name, " chan_gain b"}, shadow[CHB_GAIN], chan_gain[1]);
		check({name, " chan_gain c"}, shadow[CHC_GAIN], chan_gain[2]);
		check({name, " chan_gain d"}, shadow[CHD_GAIN], chan_gain[3]);
	endtask

	task automatic check_selects();
		logic pickup;
		pickup = shadow[CR][13] ? 1'b1 : cal_on;
		check("afe_pickup", 32'(pickup), 32'(afe_pickup));
		check("afe_cal", 32'(!pickup), 32'(afe_cal));
		check("vga_gain", 32'(vga_model()), 32'(vga_gain));
		check("sma_out", 32'(shadow[CR][3] ? !trig_in : 1'b1), 32'(sma_out));
	endtask

	// A changed setting must produce exactly one frame
	task automatic wait_att_frame();
		int n;
		if (shadow[AFE_CTRL][13:8] != att_loaded) begin
			frames_expected++;
			n = 0;
			while (att_loaded != shadow[AFE_CTRL][13:8] && n < 40) begin
				next_cycle();
				n++;
			end
			if (att_loaded != shadow[AFE_CTRL][13:8])
				fail_run("Attenuator frame did not complete after a setting change");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus transfers, entered and left 2 ns after a rising edge
	////////////////////////////////////////////////////////////////////////////
	task automatic bus_write(input logic [7:0] ofs, input logic [31:0] data);
		bus_en      = 1'b1;
		bus_we      = '1;
		bus_addr    = reg_addr(ofs);
		bus_wr_data = data;
		next_cycle();
		bus_en = 1'b0;
		bus_we = '0;
		if (ofs inside {CHA_GAIN, CHB_GAIN, CHC_GAIN, CHD_GAIN})
			shadow[ofs] = data;
		else
			shadow[ofs] = {16'h0, data[15:0]};
		check_outputs("write");
		if (ofs == AFE_CTRL)
			wait_att_frame();
	endtask

	task automatic bus_read(input logic [31:0] addr, input string name);
		logic [31:0] rel;
		bus_en   = 1'b1;
		bus_we   = '0;
		bus_addr = addr;
		next_cycle();
		bus_en = 1'b0;
		rel    = addr - BASE_ADDR;
		if (rel[1:0] == 2'b00 && rel[31:10] == '0 && mapped(rel[9:2]))
			rd_expect = expect_read(rel[9:2]);  // Otherwise the old word stays
		check(name, rd_expect, bus_rd_data);
	endtask

	task automatic partial_write();
		logic [31:0] r;
		r           = rand32();
		bus_en      = 1'b1;
		bus_we      = (r[3:0] == '0 || r[3:0] == '1) ? 4'b0110 : r[3:0];
		bus_addr    = reg_addr(pick_cfg());
		bus_wr_data = rand32();
		next_cycle();
		bus_en = 1'b0;
		bus_we = '0;
		check_outputs("partial mask");
		check("partial mask rd_data", rd_expect, bus_rd_data);
	endtask

	task automatic unmapped_read();
		logic [31:0] r;
		logic [7:0]  ofs;
		r   = rand32();
		ofs = r[7:0];
		while (mapped(ofs))
			ofs++;
		if (r[8])
			bus_read(reg_addr(ofs), "unmapped read");
		else
			bus_read(reg_addr(pick_cfg()) + {30'h0, r[10:9] | 2'b01}, "misaligned read");
	endtask

	// Attenuator frames, sampled mid cycle
	always @(negedge clk) begin
		if (!rst_n) begin
			att_nbits    = 0;
			att_bits     = '0;
			att_clk_prev = 1'b0;
		end else begin
			if (att_clk && !att_clk_prev) begin
				att_bits = {att_bits[ATT_W-2:0], att_data};  // MSB arrives first
				att_nbits++;
			end
			if (att_le) begin
				check("att frame bit count", 32'(ATT_W), 32'(att_nbits));
				check("att frame value", 32'(shadow[AFE_CTRL][13:8]), 32'(att_bits));
				att_loaded = att_bits;
				att_nbits  = 0;
				frames++;
			end
			att_clk_prev = att_clk;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] r;
		seed        = 36293;
		rst_n       = 1'b0;
		bus_en      = 1'b0;
		bus_we      = '0;
		bus_addr    = '0;
		bus_wr_data = '0;
		pos_x       = '0;
		pos_y       = '0;
		pos_s       = '0;
		chan_power  = '0;
		auto_att    = '0;
		cal_on      = 1'b0;
		trig_in     = 1'b0;
		foreach (shadow[i])
			shadow[i] = '0;
		rd_expect       = '0;
		att_loaded      = '0;
		frames          = 0;
		frames_expected = 0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;

		check_outputs("reset");
		check("reset rd_data", 32'h0, bus_rd_data);
		check("reset att pins", 32'h0, 32'({att_clk, att_le, att_data}));
		bus_read(reg_addr(FPGA_VER), "version");

		repeat (800) begin
			r = rand32();
			case (r[1:0])
				2'd0:    bus_write(pick_cfg(), rand32());
				2'd1:    bus_read(reg_addr(pick_cfg()), "config read");
				2'd2:    partial_write();
				default: unmapped_read();
			endcase
		end

		// Measurement readback
		repeat (300) begin
			r     = rand32();
			pos_x = r[15:0];
			pos_y = r[31:16];
			r     = rand32();
			pos_s = r[15:0];
			for (int i = 0; i < N_CHAN; i++)
				chan_power[i] = rand32();
			r = rand32();
			bus_read(reg_addr(meas_ofs[r % 7]), "measurement read");
		end

		// Front-end selects, attenuator field held
		repeat (300) begin
			bus_write(CR, rand32());
			r = rand32();
			if (r[0])
				bus_write(AFE_CTRL, {r[31:14], shadow[AFE_CTRL][13:8], r[7:0]});
			r        = rand32();
			cal_on   = r[0];
			trig_in  = r[1];
			auto_att = r[6:2];
			next_cycle();
			check_selects();
			bus_read(reg_addr(ACTUAL_VGA_GAIN), "actual vga gain");
		end

		repeat (100) begin
			r = rand32();
			if (r[17:16] == 2'b00)
				r[13:8] = shadow[AFE_CTRL][13:8];  // Unchanged, no frame
			bus_write(AFE_CTRL, r);
		end

		repeat (20) next_cycle();
		check("att frame count", 32'(frames_expected), 32'(frames));
		$display("Verification passed");
		$finish;
	end

endmodule
